// File: bench/cl_mem_scrub_tb.sv
// Self-checking testbench for the scrub top level that checks random traffic against a cycle model
`timescale 1ns/1ps

module cl_mem_scrub_tb;

   import scrub_pkg::*;
   import host_ctl_pkg::*;

   localparam int          NUM_DDR     = NUM_DDR_DEFAULT;
   localparam int          CLK_PERIOD  = 8;
   localparam int          BURST_LEN   = SCRB_BURST_LEN_MINUS1_DEFAULT + 1;
   localparam logic [63:0] BURST_BYTES = 64'(BURST_LEN * BEAT_BYTES);
   localparam int          NUM_BURSTS  = int'((SCRB_MAX_ADDR_DEFAULT + 64'd1) / BURST_BYTES);
   localparam logic [63:0] FINAL_ADDR  = 64'(NUM_BURSTS - 1) * BURST_BYTES;

   // Worst case for one full walk under random back-pressure
   localparam int SCRUB_TIMEOUT   = NUM_BURSTS * (BURST_LEN + 2) * 16;
   localparam int NUM_TESTS       = 5;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 4 * SCRUB_TIMEOUT;

   logic                                 clk;
   logic                                 sync_rst_n;
   logic [CTL_W-1:0]                     ctl0;
   logic                                 flr_assert;
   logic                                 flr_done;
   logic [31:0]                          id0;
   logic [31:0]                          id1;
   logic [NUM_DDR-1:0]                   ddr_is_ready;
   logic [NUM_DDR-1:0]                   ddr_awvalid;
   logic [NUM_DDR-1:0][SCRB_ADDR_W-1:0]  ddr_awaddr;
   logic [NUM_DDR-1:0]                   ddr_awready;
   logic [NUM_DDR-1:0]                   ddr_wvalid;
   logic [NUM_DDR-1:0]                   ddr_wlast;
   logic [NUM_DDR-1:0]                   ddr_wready;
   logic [NUM_DDR-1:0]                   scrub_done;
   logic [NUM_DDR-1:0][CNT_W-1:0]        ddr_aw_count;
   logic [NUM_DDR-1:0][CNT_W-1:0]        ddr_w_count;

   // Stimulus knobs applied by drive_cycle
   logic [CTL_W-1:0]   ctl_next;
   logic               flr_next;
   logic [NUM_DDR-1:0] rdy_mask;
   logic               rdy_gaps;
   logic [31:0]        rng_state;
   logic               checks_on;

   // Cycle model state
   logic [CTL_W-1:0]   m_ctl_q;
   logic               m_flr_q;
   logic               m_flr_done;
   logic [31:0]        m_id0;
   logic [31:0]        m_id1;
   scrb_state_e        m_state [NUM_DDR];
   logic [63:0]        m_addr [NUM_DDR];
   int                 m_beat [NUM_DDR];
   logic [CNT_W-1:0]   m_aw_cnt [NUM_DDR];
   logic [CNT_W-1:0]   m_w_cnt [NUM_DDR];

   // Accepted burst addresses and running beat count as seen on the DUT pins
   logic [63:0]        aw_log [NUM_DDR][$];
   int                 beats_seen [NUM_DDR];
   logic [NUM_DDR-1:0] prop_fail;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) tb_clk_gen_inst (.clk(clk));

   cl_mem_scrub_top cl_mem_scrub_top_inst (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .id0          (id0),
      .id1          (id1),
      .ddr_is_ready (ddr_is_ready),
      .ddr_awvalid  (ddr_awvalid),
      .ddr_awaddr   (ddr_awaddr),
      .ddr_awready  (ddr_awready),
      .ddr_wvalid   (ddr_wvalid),
      .ddr_wlast    (ddr_wlast),
      .ddr_wready   (ddr_wready),
      .scrub_done   (scrub_done),
      .ddr_aw_count (ddr_aw_count),
      .ddr_w_count  (ddr_w_count)
   );

   bind ddr_scrubber ddr_scrubber_properties ddr_scrubber_properties_inst (.*);

   for (genvar ch = 0; ch < NUM_DDR; ch++)
   begin : g_prop
      assign prop_fail[ch] =
         cl_mem_scrub_top_inst.g_chan[ch].ddr_scrubber_inst.ddr_scrubber_properties_inst.failed;
   end

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int rand_below(input int n);
      rng_state = lcg_next(rng_state);
      return int'(rng_state[31:16]) % n;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "run stopped on error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("Mismatch at time %0t: %s expected %0h actual %0h",
                  $time, name, expected, actual);
         $display("=== FAIL ===");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic drive_cycle();
      logic [NUM_DDR-1:0] aw_r;
      logic [NUM_DDR-1:0] w_r;
      logic [NUM_DDR-1:0] rdy_r;
      @(posedge clk);
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
         aw_r[ch]  = (rand_below(2) == 1);
         w_r[ch]   = (rand_below(2) == 1);
         rdy_r[ch] = rdy_mask[ch] && (!rdy_gaps || rand_below(8) != 0);
      end
      ctl0         <= ctl_next;
      flr_assert   <= flr_next;
      ddr_awready  <= aw_r;
      ddr_wready   <= w_r;
      ddr_is_ready <= rdy_r;
   endtask

   task automatic run_cycles(input int n);
      repeat (n)
         drive_cycle();
   endtask

   task automatic wait_all_done(input logic [NUM_DDR-1:0] mask);
      int n;
      n = 0;
      while ((scrub_done & mask) != mask)
      begin
         drive_cycle();
         n++;
         if (n > SCRUB_TIMEOUT)
            fail_run("Timed out waiting for scrub_done on the enabled channels");
      end
   endtask

   // Enables must already be clear in ctl_next
   task automatic wait_idle();
      int n;
      n = 0;
      run_cycles(3);
      while ((ddr_awvalid | ddr_wvalid | scrub_done) != '0)
      begin
         drive_cycle();
         n++;
         if (n > SCRUB_TIMEOUT)
            fail_run("Timed out waiting for the scrubbers to go idle");
      end
   endtask

   // ------------------------------------------------------------------------
   // Cycle model
   // ------------------------------------------------------------------------

   task automatic step_channel(input int ch, input logic en, input logic rdy,
                               input logic awr, input logic wr);
      case (m_state[ch])
         SCRB_IDLE:
         begin
            if (!en)
               m_addr[ch] = '0;
            else if (rdy)
               m_state[ch] = SCRB_ADDR;
         end
         SCRB_ADDR:
         begin
            if (awr)
            begin
               m_aw_cnt[ch]++;
               m_state[ch] = SCRB_DATA;
               m_beat[ch]  = 0;
            end
         end
         SCRB_DATA:
         begin
            if (wr)
            begin
               m_w_cnt[ch]++;
               if (m_beat[ch] < BURST_LEN - 1)
                  m_beat[ch]++;
               else if (!en)
               begin
                  m_state[ch] = SCRB_IDLE;
                  m_addr[ch]  = '0;
               end
               else if (m_addr[ch] + BURST_BYTES - 1 >= SCRB_MAX_ADDR_DEFAULT)
                  m_state[ch] = SCRB_DONE;
               else
               begin
                  m_addr[ch]  = m_addr[ch] + BURST_BYTES;
                  m_state[ch] = rdy ? SCRB_ADDR : SCRB_IDLE;
               end
            end
         end
         default:
         begin
            if (!en)
            begin
               m_state[ch] = SCRB_IDLE;
               m_addr[ch]  = '0;
            end
         end
      endcase
   endtask

   always @(posedge clk)
   begin : model
      int sel_ch;
      if (!sync_rst_n)
      begin
         m_ctl_q    = '0;
         m_flr_q    = 1'b0;
         m_flr_done = 1'b0;
         m_id0      = CL_ID0;
         m_id1      = CL_ID1;
         for (int ch = 0; ch < NUM_DDR; ch++)
         begin
            m_state[ch]  = SCRB_IDLE;
            m_addr[ch]   = '0;
            m_beat[ch]   = 0;
            m_aw_cnt[ch] = '0;
            m_w_cnt[ch]  = '0;
         end
      end
      else
      begin
         // ID words use the control and address as they stood before this edge
         sel_ch = int'(m_ctl_q[DBG_SEL_LSB +: DBG_SEL_W]);
         if (sel_ch >= NUM_DDR)
            sel_ch = 0;
         m_id0 = m_ctl_q[DBG_EN_BIT] ? m_addr[sel_ch][31:0] : CL_ID0;
         m_id1 = m_ctl_q[DBG_EN_BIT] ? m_addr[sel_ch][63:32] : CL_ID1;
         m_flr_done = m_flr_q && !m_flr_done;
         m_flr_q    = flr_assert;
         for (int ch = 0; ch < NUM_DDR; ch++)
            step_channel(ch, m_ctl_q[ch], ddr_is_ready[ch], ddr_awready[ch], ddr_wready[ch]);
         m_ctl_q = ctl0;
      end
   end

   // ------------------------------------------------------------------------
   // Per-cycle compare on the falling edge
   // ------------------------------------------------------------------------

   always @(negedge clk)
   begin
      if (checks_on)
      begin
         check_value("flr_done", m_flr_done, flr_done);
         check_value("id0", m_id0, id0);
         check_value("id1", m_id1, id1);
         check_value("assertion failures", '0, prop_fail);
         for (int ch = 0; ch < NUM_DDR; ch++)
         begin
            check_value($sformatf("ddr_awvalid[%0d]", ch), m_state[ch] == SCRB_ADDR,
                        ddr_awvalid[ch]);
            check_value($sformatf("ddr_awaddr[%0d]", ch), m_addr[ch], ddr_awaddr[ch]);
            check_value($sformatf("ddr_wvalid[%0d]", ch), m_state[ch] == SCRB_DATA,
                        ddr_wvalid[ch]);
            check_value($sformatf("ddr_wlast[%0d]", ch),
                        m_state[ch] == SCRB_DATA && m_beat[ch] == BURST_LEN - 1,
                        ddr_wlast[ch]);
            check_value($sformatf("scrub_done[%0d]", ch), m_state[ch] == SCRB_DONE,
                        scrub_done[ch]);
            check_value($sformatf("ddr_aw_count[%0d]", ch), m_aw_cnt[ch], ddr_aw_count[ch]);
            check_value($sformatf("ddr_w_count[%0d]", ch), m_w_cnt[ch], ddr_w_count[ch]);
            if (ddr_awvalid[ch] && ddr_awready[ch])
               aw_log[ch].push_back(ddr_awaddr[ch]);
            if (ddr_wvalid[ch] && ddr_wready[ch])
            begin
               beats_seen[ch]++;
               if (ddr_wlast[ch])
               begin
                  check_value($sformatf("beats per burst[%0d]", ch), BURST_LEN,
                              beats_seen[ch]);
                  beats_seen[ch] = 0;
               end
            end
         end
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      fail_run("Watchdog expired, the tests did not finish in time");
   end

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial
   begin
      rng_state    = 32'h5dfcff13;
      checks_on    = 1'b0;
      sync_rst_n   = 1'b0;
      ctl0         = '0;
      flr_assert   = 1'b0;
      ddr_is_ready = '0;
      ddr_awready  = '0;
      ddr_wready   = '0;
      ctl_next     = '0;
      flr_next     = 1'b0;
      rdy_mask     = '1;
      rdy_gaps     = 1'b0;
      for (int ch = 0; ch < NUM_DDR; ch++)
         beats_seen[ch] = 0;
      repeat (4) @(posedge clk);
      sync_rst_n <= 1'b1;
      checks_on = 1'b1;

      // Full scrub of every channel under back-pressure and readiness gaps
      rdy_gaps = 1'b1;
      ctl_next = CTL_W'({NUM_DDR{1'b1}});
      wait_all_done('1);
      run_cycles(20);
      @(negedge clk);
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
         check_value($sformatf("burst count[%0d]", ch), NUM_BURSTS, aw_log[ch].size());
         for (int k = 0; k < aw_log[ch].size(); k++)
            check_value($sformatf("burst address[%0d]", ch), 64'(k) * BURST_BYTES,
                        aw_log[ch][k]);
         check_value($sformatf("ddr_w_count[%0d] after scrub", ch),
                     NUM_BURSTS * BURST_LEN, ddr_w_count[ch]);
      end

      // Debug readback with channel 0 dropped so that its address reads back as zero
      run_cycles(2);
      check_value("id0 debug off", CL_ID0, id0);
      check_value("id1 debug off", CL_ID1, id1);
      ctl_next = CTL_W'({NUM_DDR{1'b1}}) & ~CTL_W'(1);
      run_cycles(4);
      for (int sel = 0; sel < (1 << DBG_SEL_W); sel++)
      begin
         ctl_next[DBG_EN_BIT] = 1'b1;
         ctl_next[DBG_SEL_LSB +: DBG_SEL_W] = DBG_SEL_W'(sel);
         run_cycles(3);
         @(negedge clk);
         check_value("id0 debug", (sel == 0 || sel >= NUM_DDR) ? 32'd0 : FINAL_ADDR[31:0], id0);
         check_value("id1 debug", (sel == 0 || sel >= NUM_DDR) ? 32'd0 : FINAL_ADDR[63:32], id1);
      end

      // Enable and readiness gating where only channel 0 may move
      ctl_next = '0;
      wait_idle();
      check_value("scrub_done after drop", '0, scrub_done);
      for (int ch = 0; ch < NUM_DDR; ch++)
         aw_log[ch].delete();
      rdy_gaps = 1'b0;
      rdy_mask = NUM_DDR'(3);
      ctl_next = CTL_W'(5);
      repeat (200)
      begin
         drive_cycle();
         check_value("gated valid", '0, (ddr_awvalid | ddr_wvalid) & ~NUM_DDR'(1));
      end
      check_value("first address ch0", 64'd0, aw_log[0].size() > 0 ? aw_log[0][0] : 64'hdead);
      for (int ch = 1; ch < NUM_DDR; ch++)
         check_value($sformatf("gated bursts[%0d]", ch), 0, aw_log[ch].size());

      // A drop mid-walk restarts from address zero
      ctl_next = '0;
      rdy_mask = '1;
      wait_idle();
      aw_log[0].delete();
      ctl_next = CTL_W'(1);
      wait_all_done(NUM_DDR'(1));
      check_value("restart address", 64'd0, aw_log[0][0]);

      // Random enable, drop and debug patterns with counters tracked by the model
      rdy_gaps = 1'b1;
      repeat (12)
      begin
         ctl_next = {rand_below(2) == 1, 3'(rand_below(8)), 24'd0, 4'(rand_below(16))};
         run_cycles(20 + rand_below(400));
      end
      @(negedge clk);
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
         check_value($sformatf("final ddr_aw_count[%0d]", ch), m_aw_cnt[ch], ddr_aw_count[ch]);
         check_value($sformatf("final ddr_w_count[%0d]", ch), m_w_cnt[ch], ddr_w_count[ch]);
      end

      // FLR assert held for random lengths while done toggles
      repeat (30)
      begin
         flr_next = 1'b1;
         run_cycles(1 + rand_below(10));
         flr_next = 1'b0;
         run_cycles(1 + rand_below(6));
      end
      run_cycles(4);
      @(negedge clk);
      check_value("assertion failures at end", '0, prop_fail);

      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: bench/ddr_scrubber_properties.sv
// Handshake assertions for one scrubber, bound into every ddr_scrubber by the testbench
`timescale 1ns/1ps

module ddr_scrubber_properties
(
   input logic                              clk,
   input logic                              sync_rst_n,
   input logic                              awvalid,
   input logic [scrub_pkg::SCRB_ADDR_W-1:0] awaddr,
   input logic                              awready,
   input logic                              wvalid,
   input logic                              wready,
   input logic                              scrub_done
);

   // Set by any failing assertion, watched from the testbench top
   logic failed = 1'b0;

   aw_hold : assert property (@(posedge clk) disable iff (!sync_rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr))
   else
   begin
      $error("awvalid dropped or awaddr moved before awready");
      failed = 1'b1;
   end

   w_hold : assert property (@(posedge clk) disable iff (!sync_rst_n)
      wvalid && !wready |=> wvalid)
   else
   begin
      $error("wvalid dropped before wready");
      failed = 1'b1;
   end

   idle_when_done : assert property (@(posedge clk) disable iff (!sync_rst_n)
      scrub_done |-> !awvalid && !wvalid)
   else
   begin
      $error("valid asserted while scrub_done is high");
      failed = 1'b1;
   end

endmodule

// File: bench/tb_clk_gen.sv
// Free-running testbench clock source, instantiated once by the scrub testbench
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS = 8
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

// File: common/host_ctl_pkg.sv
// Host control word layout and identification constants used by the control block and testbench
package host_ctl_pkg;

   // ------------------------------------------------------------------------
   // Control word
   // ------------------------------------------------------------------------

   parameter int CTL_W = 32;

   // Low bits are the per-channel scrub enables, bit i for channel i

   // Debug readback enable, swaps the ID words for a scrub address
   parameter int DBG_EN_BIT = 31;

   // Channel select for the debug readback
   parameter int DBG_SEL_LSB = 28;
   parameter int DBG_SEL_W   = 3;

   // ------------------------------------------------------------------------
   // Identification words
   // ------------------------------------------------------------------------

   // Device ID in the upper half, vendor ID in the lower half
   parameter logic [31:0] CL_ID0 = 32'h5C7B_1A2C;

   // Subsystem ID in the upper half, subsystem vendor ID in the lower half
   parameter logic [31:0] CL_ID1 = 32'h0001_1A2C;

endpackage

// File: common/scrub_pkg.sv
// Scrubber geometry, counter width and FSM state type shared by the scrub RTL and its testbench
package scrub_pkg;

   // ------------------------------------------------------------------------
   // Channel count
   // ------------------------------------------------------------------------

   // Number of DDR channels the top level builds unless told otherwise
   parameter int NUM_DDR_DEFAULT = 4;

   // ------------------------------------------------------------------------
   // Address and burst geometry
   // ------------------------------------------------------------------------

   // Byte address width on the write address channel
   parameter int SCRB_ADDR_W = 64;

   // Bytes carried by one write beat (512-bit data path)
   parameter int BEAT_BYTES = 64;

   // Last byte scrubbed, 8 KiB region keeps simulation short
   parameter logic [SCRB_ADDR_W-1:0] SCRB_MAX_ADDR_DEFAULT = 64'h0000_0000_0000_1FFF;

   // Beats per burst minus one
   parameter int SCRB_BURST_LEN_MINUS1_DEFAULT = 15;

   // ------------------------------------------------------------------------
   // Traffic counters
   // ------------------------------------------------------------------------

   parameter int CNT_W = 32;

   // ------------------------------------------------------------------------
   // Scrubber FSM
   // ------------------------------------------------------------------------

   typedef enum logic [1:0] {
      SCRB_IDLE = 2'd0,
      SCRB_ADDR = 2'd1,
      SCRB_DATA = 2'd2,
      SCRB_DONE = 2'd3
   } scrb_state_e;

endpackage

// File: filelist.f
common/scrub_pkg.sv
common/host_ctl_pkg.sv
source/host_ctl_regs.sv
scrubber/ddr_scrubber.sv
source/ddr_traffic_counter.sv
source/cl_mem_scrub_top.sv
bench/tb_clk_gen.sv
bench/ddr_scrubber_properties.sv
bench/cl_mem_scrub_tb.sv

// File: scrubber/ddr_scrubber.sv
// Zero-fill scrubber for one DDR channel, walks memory in fixed bursts of AW then W beats
`timescale 1ns/1ps

module ddr_scrubber #(
   parameter logic [scrub_pkg::SCRB_ADDR_W-1:0] SCRB_MAX_ADDR = scrub_pkg::SCRB_MAX_ADDR_DEFAULT,
   parameter int SCRB_BURST_LEN_MINUS1 = scrub_pkg::SCRB_BURST_LEN_MINUS1_DEFAULT
)
(
   input  logic                              clk,
   input  logic                              sync_rst_n,

   input  logic                              scrub_en,
   input  logic                              ddr_is_ready,

   // Write address channel
   output logic                              awvalid,
   output logic [scrub_pkg::SCRB_ADDR_W-1:0] awaddr,
   input  logic                              awready,

   // Write data channel, data is all zero so only the framing leaves
   output logic                              wvalid,
   output logic                              wlast,
   input  logic                              wready,

   output logic                              scrub_done,
   output logic [scrub_pkg::SCRB_ADDR_W-1:0] scrub_addr
);

   import scrub_pkg::*;

   localparam int BEAT_CNT_W =
      (SCRB_BURST_LEN_MINUS1 > 0) ? $clog2(SCRB_BURST_LEN_MINUS1 + 1) : 1;

   // Bytes covered by one burst
   localparam logic [SCRB_ADDR_W-1:0] BURST_BYTES =
      SCRB_ADDR_W'((SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   scrb_state_e            state;
   logic [SCRB_ADDR_W-1:0] addr;
   logic [BEAT_CNT_W-1:0]  beat_cnt;
   logic [SCRB_ADDR_W-1:0] burst_end;
   logic                   last_beat;
   logic                   last_burst;

   assign burst_end  = addr + (BURST_BYTES - 1'b1);
   assign last_burst = (burst_end >= SCRB_MAX_ADDR);
   assign last_beat  = (beat_cnt == BEAT_CNT_W'(SCRB_BURST_LEN_MINUS1));

   // ------------------------------------------------------------------------
   // Walk FSM
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state    <= SCRB_IDLE;
         addr     <= '0;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            SCRB_IDLE:
            begin
               // A paused walk keeps its address while enabled
               if (!scrub_en)
                  addr <= '0;
               else if (ddr_is_ready)
                  state <= SCRB_ADDR;
            end
            SCRB_ADDR:
            begin
               if (awready)
               begin
                  state    <= SCRB_DATA;
                  beat_cnt <= '0;
               end
            end
            SCRB_DATA:
            begin
               if (wready)
               begin
                  if (!last_beat)
                     beat_cnt <= beat_cnt + 1'b1;
                  // Burst boundary, the only place the enable is looked at mid-walk
                  else if (!scrub_en)
                  begin
                     state <= SCRB_IDLE;
                     addr  <= '0;
                  end
                  else if (last_burst)
                     state <= SCRB_DONE;
                  else
                  begin
                     addr  <= addr + BURST_BYTES;
                     state <= ddr_is_ready ? SCRB_ADDR : SCRB_IDLE;
                  end
               end
            end
            SCRB_DONE:
            begin
               if (!scrub_en)
               begin
                  state <= SCRB_IDLE;
                  addr  <= '0;
               end
            end
            default:
               state <= SCRB_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Outputs
   // ------------------------------------------------------------------------

   assign awvalid    = (state == SCRB_ADDR);
   assign awaddr     = addr;
   assign wvalid     = (state == SCRB_DATA);
   assign wlast      = (state == SCRB_DATA) && last_beat;
   assign scrub_done = (state == SCRB_DONE);
   assign scrub_addr = addr;

endmodule

// File: source/cl_mem_scrub_top.sv
// Memory scrub top level: host control block plus one scrubber and traffic counter per DDR channel
`timescale 1ns/1ps

module cl_mem_scrub_top #(
   parameter int NUM_DDR = scrub_pkg::NUM_DDR_DEFAULT,
   parameter logic [scrub_pkg::SCRB_ADDR_W-1:0] SCRB_MAX_ADDR = scrub_pkg::SCRB_MAX_ADDR_DEFAULT,
   parameter int SCRB_BURST_LEN_MINUS1 = scrub_pkg::SCRB_BURST_LEN_MINUS1_DEFAULT
)
(
   input  logic                                           clk,
   input  logic                                           sync_rst_n,

   // Host side
   input  logic [host_ctl_pkg::CTL_W-1:0]                 ctl0,
   input  logic                                           flr_assert,
   output logic                                           flr_done,
   output logic [31:0]                                    id0,
   output logic [31:0]                                    id1,

   // Per-channel write traffic
   input  logic [NUM_DDR-1:0]                             ddr_is_ready,
   output logic [NUM_DDR-1:0]                             ddr_awvalid,
   output logic [NUM_DDR-1:0][scrub_pkg::SCRB_ADDR_W-1:0] ddr_awaddr,
   input  logic [NUM_DDR-1:0]                             ddr_awready,
   output logic [NUM_DDR-1:0]                             ddr_wvalid,
   output logic [NUM_DDR-1:0]                             ddr_wlast,
   input  logic [NUM_DDR-1:0]                             ddr_wready,

   // Status
   output logic [NUM_DDR-1:0]                             scrub_done,
   output logic [NUM_DDR-1:0][scrub_pkg::CNT_W-1:0]       ddr_aw_count,
   output logic [NUM_DDR-1:0][scrub_pkg::CNT_W-1:0]       ddr_w_count
);

   import scrub_pkg::*;

   logic [NUM_DDR-1:0]                  scrub_en;
   logic [NUM_DDR-1:0][SCRB_ADDR_W-1:0] scrub_addr;

   // ------------------------------------------------------------------------
   // Host control
   // ------------------------------------------------------------------------

   host_ctl_regs #(
      .NUM_DDR    (NUM_DDR)
   ) host_ctl_regs_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .scrub_addr (scrub_addr),
      .scrub_en   (scrub_en),
      .flr_done   (flr_done),
      .id0        (id0),
      .id1        (id1)
   );

   // ------------------------------------------------------------------------
   // Per-channel scrubber and counter
   // ------------------------------------------------------------------------

   for (genvar ch = 0; ch < NUM_DDR; ch++)
   begin : g_chan
      ddr_scrubber #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      ) ddr_scrubber_inst (
         .clk          (clk),
         .sync_rst_n   (sync_rst_n),
         .scrub_en     (scrub_en[ch]),
         .ddr_is_ready (ddr_is_ready[ch]),
         .awvalid      (ddr_awvalid[ch]),
         .awaddr       (ddr_awaddr[ch]),
         .awready      (ddr_awready[ch]),
         .wvalid       (ddr_wvalid[ch]),
         .wlast        (ddr_wlast[ch]),
         .wready       (ddr_wready[ch]),
         .scrub_done   (scrub_done[ch]),
         .scrub_addr   (scrub_addr[ch])
      );

      // Watches the same handshakes the scrubber sees
      ddr_traffic_counter ddr_traffic_counter_inst (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .awvalid    (ddr_awvalid[ch]),
         .awready    (ddr_awready[ch]),
         .wvalid     (ddr_wvalid[ch]),
         .wready     (ddr_wready[ch]),
         .aw_count   (ddr_aw_count[ch]),
         .w_count    (ddr_w_count[ch])
      );
   end

endmodule

// File: source/ddr_traffic_counter.sv
// Counts accepted write address and write data handshakes on one DDR channel
`timescale 1ns/1ps

module ddr_traffic_counter
(
   input  logic                        clk,
   input  logic                        sync_rst_n,

   input  logic                        awvalid,
   input  logic                        awready,
   input  logic                        wvalid,
   input  logic                        wready,

   output logic [scrub_pkg::CNT_W-1:0] aw_count,
   output logic [scrub_pkg::CNT_W-1:0] w_count
);

   logic aw_fire;
   logic w_fire;

   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;

   // Both counters wrap silently
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         aw_count <= '0;
         w_count  <= '0;
      end
      else
      begin
         if (aw_fire)
            aw_count <= aw_count + 1'b1;
         if (w_fire)
            w_count <= w_count + 1'b1;
      end
   end

endmodule

// File: source/host_ctl_regs.sv
// Host control register: scrub enables, debug ID readback and FLR done pulse for the scrub top
`timescale 1ns/1ps

module host_ctl_regs #(
   parameter int NUM_DDR = scrub_pkg::NUM_DDR_DEFAULT
)
(
   input  logic                                           clk,
   input  logic                                           sync_rst_n,

   input  logic [host_ctl_pkg::CTL_W-1:0]                 ctl0,
   input  logic                                           flr_assert,
   input  logic [NUM_DDR-1:0][scrub_pkg::SCRB_ADDR_W-1:0] scrub_addr,

   output logic [NUM_DDR-1:0]                             scrub_en,
   output logic                                           flr_done,
   output logic [31:0]                                    id0,
   output logic [31:0]                                    id1
);

   import host_ctl_pkg::*;
   import scrub_pkg::*;

   logic [CTL_W-1:0]       ctl0_q;
   logic                   flr_assert_q;
   logic                   dbg_en;
   logic [DBG_SEL_W-1:0]   dbg_sel;
   logic [SCRB_ADDR_W-1:0] sel_addr;

   // ------------------------------------------------------------------------
   // Control word capture
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         ctl0_q <= '0;
      else
         ctl0_q <= ctl0;
   end

   assign scrub_en = ctl0_q[NUM_DDR-1:0];
   assign dbg_en   = ctl0_q[DBG_EN_BIT];
   assign dbg_sel  = ctl0_q[DBG_SEL_LSB +: DBG_SEL_W];

   // ------------------------------------------------------------------------
   // Debug readback
   // ------------------------------------------------------------------------

   // Unknown channel numbers fall back to channel 0
   always_comb
   begin
      sel_addr = scrub_addr[0];
      for (int i = 1; i < NUM_DDR; i++)
      begin
         if (dbg_sel == i)
            sel_addr = scrub_addr[i];
      end
   end

   // ID words follow the registered control word, so ctl0 shows up two cycles later
   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[SCRB_ADDR_W-1:32];
      end
      else
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
   end

   // ------------------------------------------------------------------------
   // FLR response
   // ------------------------------------------------------------------------

   // Done toggles for as long as the assert stays high
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule
